//--- rtl/lc4_settings.svh
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

// ========================================
// Datapath geometry
// ========================================
`define LC4_WORD_W   16        // Data and address width
`define LC4_REG_N    8         // Register file depth
`define LC4_REG_W    3         // Register selector width

// Fetch address out of reset
`define LC4_RESET_PC 16'h8200

// ========================================
// Immediate field widths
// ========================================
`define LC4_IMM5_W   5         // ADD immediate
`define LC4_IMM6_W   6         // LDR/STR offset
`define LC4_IMM9_W   9         // BR offset, CONST value
`define LC4_IMM11_W  11        // JMP offset

`endif

//--- rtl/lc4_pkg.sv
`include "lc4_settings.svh"

`default_nettype none

package lc4_pkg;

   typedef logic [`LC4_WORD_W-1:0] word_t;
   typedef logic [`LC4_REG_W-1:0]  reg_sel_t;

   // Major opcode, insn[15:12]
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,      // NOP is BR with empty mask
      OP_ARITH = 4'b0001,      // ADD, SUB, ADD imm5
      OP_LOGIC = 4'b0101,      // AND, OR, XOR
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001,
      OP_JMP   = 4'b1100       // JMP needs insn[11] set
   } opcode_e;

   // What execute computes
   typedef enum logic [2:0] {
      ALU_ADD,                 // Also LDR/STR address
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B,              // CONST
      ALU_PC_REL               // PC+1+imm, branch and jump target
   } alu_op_e;

endpackage

`default_nettype wire

//--- rtl/lc4_fetch.sv
`include "lc4_settings.svh"

`default_nettype none

module lc4_fetch (
   input  wire                gwe,
   input  wire                i_reset,
   input  wire                i_stall,     // Load-use hold from decode
   input  wire                i_redirect,  // Taken branch or JMP in execute
   input  wire lc4_pkg::word_t i_target,
   input  wire lc4_pkg::word_t i_insn,     // Imem data at o_pc
   output lc4_pkg::word_t     o_pc,
   output lc4_pkg::word_t     o_d_insn,
   output lc4_pkg::word_t     o_d_pc
);

   import lc4_pkg::*;

   word_t pc;

   assign o_pc = pc;

   // PC and F/D instruction register
   // Redirect wins over stall
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc       <= `LC4_RESET_PC;
         o_d_insn <= '0;              // NOP
      end else if (i_redirect) begin
         pc       <= i_target;
         o_d_insn <= '0;              // Squash wrong-path fetch
      end else if (!i_stall) begin
         pc       <= pc + word_t'(1);
         o_d_insn <= i_insn;
      end
   end

   // PC copy for PC-relative targets
   always_ff @(posedge gwe) begin
      if (!i_stall || i_redirect) begin
         o_d_pc <= pc;
      end
   end

endmodule

`default_nettype wire

//--- rtl/lc4_decode.sv
`include "lc4_settings.svh"

`default_nettype none

module lc4_decode (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire lc4_pkg::word_t     i_insn,
   input  wire lc4_pkg::word_t     i_pc,
   input  wire                    i_flush,       // Redirect from execute
   input  wire                    i_x_is_load,
   input  wire lc4_pkg::reg_sel_t  i_x_rd,
   input  wire                    i_w_we,        // Register file write port
   input  wire lc4_pkg::reg_sel_t  i_w_rd,
   input  wire lc4_pkg::word_t     i_w_data,
   output logic                   o_stall,
   output lc4_pkg::alu_op_e       o_x_op,
   output lc4_pkg::word_t         o_x_imm,
   output lc4_pkg::reg_sel_t      o_x_rs,
   output lc4_pkg::reg_sel_t      o_x_rt,
   output lc4_pkg::reg_sel_t      o_x_rd,
   output lc4_pkg::word_t         o_x_rs_val,
   output lc4_pkg::word_t         o_x_rt_val,
   output logic                   o_x_regfile_we,
   output logic                   o_x_nzp_we,
   output logic                   o_x_is_load,
   output logic                   o_x_is_store,
   output logic                   o_x_is_branch,
   output logic                   o_x_is_jmp,
   output logic                   o_x_use_imm,   // ALU B from immediate
   output logic [2:0]             o_x_nzp,       // Branch mask
   output lc4_pkg::word_t         o_x_pc
);

   import lc4_pkg::*;

   word_t    rf [`LC4_REG_N];
   opcode_e  opcode;
   alu_op_e  d_op;
   word_t    d_imm, imm5, imm6, imm9, imm11;
   word_t    rs_val, rt_val;
   reg_sel_t d_rs, d_rt, d_rd;
   logic     d_rs_re, d_rt_re;        // Sources that feed the ALU
   logic     d_we, d_nzp_we, d_load, d_store, d_branch, d_jmp, d_use_imm;
   logic     kill;

   assign opcode = opcode_e'(i_insn[15:12]);
   assign d_rd   = i_insn[11:9];
   assign d_rs   = i_insn[8:6];

   // Sign-extended immediates
   assign imm5  = {{(`LC4_WORD_W-`LC4_IMM5_W){i_insn[`LC4_IMM5_W-1]}},
                   i_insn[`LC4_IMM5_W-1:0]};
   assign imm6  = {{(`LC4_WORD_W-`LC4_IMM6_W){i_insn[`LC4_IMM6_W-1]}},
                   i_insn[`LC4_IMM6_W-1:0]};
   assign imm9  = {{(`LC4_WORD_W-`LC4_IMM9_W){i_insn[`LC4_IMM9_W-1]}},
                   i_insn[`LC4_IMM9_W-1:0]};
   assign imm11 = {{(`LC4_WORD_W-`LC4_IMM11_W){i_insn[`LC4_IMM11_W-1]}},
                   i_insn[`LC4_IMM11_W-1:0]};

   // ========================================
   // Instruction decoder
   // ========================================
   always_comb begin
      d_op      = ALU_ADD;
      d_imm     = imm6;
      d_rt      = i_insn[2:0];
      d_rs_re   = 1'b0;
      d_rt_re   = 1'b0;
      d_we      = 1'b0;
      d_nzp_we  = 1'b0;
      d_load    = 1'b0;
      d_store   = 1'b0;
      d_branch  = 1'b0;
      d_jmp     = 1'b0;
      d_use_imm = 1'b0;
      case (opcode)
         OP_BR: begin
            d_branch = 1'b1;          // Empty mask never taken
            d_op     = ALU_PC_REL;
            d_imm    = imm9;
         end
         OP_ARITH: begin
            d_imm     = imm5;
            d_use_imm = i_insn[5];
            d_op      = (i_insn[5:3] == 3'b010) ? ALU_SUB : ALU_ADD;
            if (i_insn[5] || i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
               d_rs_re  = 1'b1;
               d_rt_re  = !i_insn[5];
               d_we     = 1'b1;
               d_nzp_we = 1'b1;
            end
         end
         OP_LOGIC: begin
            d_op = (i_insn[5:3] == 3'b010) ? ALU_OR  :
                   (i_insn[5:3] == 3'b011) ? ALU_XOR : ALU_AND;
            if (i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010 || i_insn[5:3] == 3'b011) begin
               d_rs_re  = 1'b1;
               d_rt_re  = 1'b1;
               d_we     = 1'b1;
               d_nzp_we = 1'b1;
            end
         end
         OP_LDR: begin
            d_rs_re   = 1'b1;
            d_we      = 1'b1;
            d_load    = 1'b1;
            d_use_imm = 1'b1;
         end
         OP_STR: begin
            d_rt      = i_insn[11:9];  // Store data register
            d_rs_re   = 1'b1;
            d_store   = 1'b1;
            d_use_imm = 1'b1;
         end
         OP_CONST: begin
            d_op      = ALU_PASS_B;
            d_imm     = imm9;
            d_we      = 1'b1;
            d_nzp_we  = 1'b1;
            d_use_imm = 1'b1;
         end
         OP_JMP: begin
            d_op  = ALU_PC_REL;
            d_imm = imm11;
            d_jmp = i_insn[11];        // JMPR not supported
         end
         default: ;                    // Unsupported opcodes run as NOP
      endcase
   end

   // Register file written at end of writeback
   always_ff @(posedge gwe) begin
      if (i_w_we) begin
         rf[i_w_rd] <= i_w_data;
      end
   end

   // WD bypass
   assign rs_val = (i_w_we && i_w_rd == d_rs) ? i_w_data : rf[d_rs];
   assign rt_val = (i_w_we && i_w_rd == d_rt) ? i_w_data : rf[d_rt];

   // Load-use hazard on ALU sources only
   assign o_stall = i_x_is_load &&
                    ((d_rs_re && i_x_rd == d_rs) || (d_rt_re && i_x_rd == d_rt));
   assign kill    = o_stall || i_flush;

   // ========================================
   // D/X register
   // ========================================
   always_ff @(posedge gwe) begin
      if (i_reset || kill) begin      // Bubble
         o_x_regfile_we <= 1'b0;
         o_x_nzp_we     <= 1'b0;
         o_x_is_load    <= 1'b0;
         o_x_is_store   <= 1'b0;
         o_x_is_branch  <= 1'b0;
         o_x_is_jmp     <= 1'b0;
      end else begin
         o_x_regfile_we <= d_we;
         o_x_nzp_we     <= d_nzp_we;
         o_x_is_load    <= d_load;
         o_x_is_store   <= d_store;
         o_x_is_branch  <= d_branch;
         o_x_is_jmp     <= d_jmp;
      end
   end

   always_ff @(posedge gwe) begin
      o_x_op      <= d_op;
      o_x_imm     <= d_imm;
      o_x_rs      <= d_rs;
      o_x_rt      <= d_rt;
      o_x_rd      <= d_rd;
      o_x_rs_val  <= rs_val;
      o_x_rt_val  <= rt_val;
      o_x_use_imm <= d_use_imm;
      o_x_nzp     <= i_insn[11:9];
      o_x_pc      <= i_pc;
   end

   // Load-use stall lasts a single cycle, the bubble frees execute
   a_stall_once: assert property (@(posedge gwe) disable iff (i_reset)
      o_stall |=> !o_stall);

endmodule

`default_nettype wire

//--- rtl/lc4_execute.sv
`include "lc4_settings.svh"

`default_nettype none

module lc4_execute (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire lc4_pkg::alu_op_e   i_op,
   input  wire lc4_pkg::word_t     i_imm,
   input  wire lc4_pkg::reg_sel_t  i_rs,
   input  wire lc4_pkg::reg_sel_t  i_rt,
   input  wire lc4_pkg::reg_sel_t  i_rd,
   input  wire lc4_pkg::word_t     i_rs_val,
   input  wire lc4_pkg::word_t     i_rt_val,
   input  wire                    i_regfile_we,
   input  wire                    i_nzp_we,
   input  wire                    i_is_load,
   input  wire                    i_is_store,
   input  wire                    i_is_branch,
   input  wire                    i_is_jmp,
   input  wire                    i_use_imm,
   input  wire [2:0]              i_nzp,        // Branch mask
   input  wire lc4_pkg::word_t     i_pc,
   input  wire                    i_m_we,       // MX source
   input  wire lc4_pkg::reg_sel_t  i_m_rd,
   input  wire lc4_pkg::word_t     i_m_data,
   input  wire                    i_w_we,       // WX source
   input  wire lc4_pkg::reg_sel_t  i_w_rd,
   input  wire lc4_pkg::word_t     i_w_data,
   output logic                   o_redirect,
   output lc4_pkg::word_t         o_target,
   output logic                   o_x_is_load,  // Back to hazard check
   output lc4_pkg::reg_sel_t      o_x_rd,
   output lc4_pkg::word_t         o_m_alu,
   output lc4_pkg::word_t         o_m_rt_val,
   output lc4_pkg::reg_sel_t      o_m_rt,
   output lc4_pkg::reg_sel_t      o_m_rd,
   output logic                   o_m_regfile_we,
   output logic                   o_m_is_load,
   output logic                   o_m_is_store
);

   import lc4_pkg::*;

   word_t      rs_fwd, rt_fwd;
   word_t      alu_b, alu;
   logic [2:0] nzp, nzp_new;
   logic       taken;

   assign o_x_is_load = i_is_load;
   assign o_x_rd      = i_rd;

   // ========================================
   // Bypass with MX before WX
   // ========================================
   assign rs_fwd = (i_m_we && i_m_rd == i_rs) ? i_m_data :
                   (i_w_we && i_w_rd == i_rs) ? i_w_data : i_rs_val;
   assign rt_fwd = (i_m_we && i_m_rd == i_rt) ? i_m_data :
                   (i_w_we && i_w_rd == i_rt) ? i_w_data : i_rt_val;

   assign alu_b = i_use_imm ? i_imm : rt_fwd;

   always_comb begin
      case (i_op)
         ALU_ADD:    alu = rs_fwd + alu_b;
         ALU_SUB:    alu = rs_fwd - alu_b;
         ALU_AND:    alu = rs_fwd & alu_b;
         ALU_OR:     alu = rs_fwd | alu_b;
         ALU_XOR:    alu = rs_fwd ^ alu_b;
         ALU_PC_REL: alu = i_pc + word_t'(1) + i_imm;
         default:    alu = alu_b;         // PASS_B
      endcase
   end

   // Condition codes of the result
   assign nzp_new = alu[`LC4_WORD_W-1] ? 3'b100 :
                    (alu == '0)         ? 3'b010 : 3'b001;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp <= 3'b000;
      end else if (i_nzp_we) begin
         nzp <= nzp_new;
      end
   end

   // Branch resolution
   assign taken      = i_is_branch && |(i_nzp & nzp);
   assign o_redirect = taken || i_is_jmp;
   assign o_target   = alu;

   // ========================================
   // X/M register
   // ========================================
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_m_regfile_we <= 1'b0;
         o_m_is_load    <= 1'b0;
         o_m_is_store   <= 1'b0;
      end else begin
         o_m_regfile_we <= i_regfile_we;
         o_m_is_load    <= i_is_load;
         o_m_is_store   <= i_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      o_m_alu    <= alu;
      o_m_rt_val <= rt_fwd;         // Store data that WM may still patch
      o_m_rt     <= i_rt;
      o_m_rd     <= i_rd;
   end

   // The flush leaves a bubble in execute behind every redirect
   a_redirect: assert property (@(posedge gwe) disable iff (i_reset)
      o_redirect |=> !o_redirect);

endmodule

`default_nettype wire

//--- rtl/lc4_result.sv
`default_nettype none

module lc4_result (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire lc4_pkg::word_t     i_m_alu,
   input  wire lc4_pkg::word_t     i_m_rt_val,
   input  wire lc4_pkg::reg_sel_t  i_m_rt,
   input  wire lc4_pkg::reg_sel_t  i_m_rd,
   input  wire                    i_m_regfile_we,
   input  wire                    i_m_is_load,
   input  wire                    i_m_is_store,
   input  wire lc4_pkg::word_t     i_dmem_data,
   output lc4_pkg::word_t         o_dmem_addr,
   output logic                   o_dmem_we,
   output lc4_pkg::word_t         o_dmem_wdata,
   output logic                   o_m_we,       // MX source
   output lc4_pkg::reg_sel_t      o_m_rd,
   output lc4_pkg::word_t         o_m_data,
   output logic                   o_w_we,       // Regfile write, WX and WM source
   output lc4_pkg::reg_sel_t      o_w_rd,
   output lc4_pkg::word_t         o_w_data
);

   import lc4_pkg::*;

   word_t w_alu, w_load;
   logic  w_is_load;

   // ========================================
   // Memory stage
   // ========================================
   assign o_dmem_addr  = i_m_alu;
   assign o_dmem_we    = i_m_is_store;
   // WM bypass of store data
   assign o_dmem_wdata = (o_w_we && o_w_rd == i_m_rt) ? o_w_data : i_m_rt_val;

   // Load data not ready until writeback
   assign o_m_we   = i_m_regfile_we && !i_m_is_load;
   assign o_m_rd   = i_m_rd;
   assign o_m_data = i_m_alu;

   // M/W register
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_w_we    <= 1'b0;
         w_is_load <= 1'b0;
      end else begin
         o_w_we    <= i_m_regfile_we;
         w_is_load <= i_m_is_load;
      end
   end

   always_ff @(posedge gwe) begin
      o_w_rd <= i_m_rd;
      w_alu  <= i_m_alu;
      w_load <= i_dmem_data;      // Sampled at end of memory cycle
   end

   // Writeback select
   assign o_w_data = w_is_load ? w_load : w_alu;

   // Decoder never marks an instruction as both load and store
   a_no_load_store: assert property (@(posedge gwe) disable iff (i_reset)
      !(o_dmem_we && i_m_is_load));

endmodule

`default_nettype wire

//--- rtl/lc4_core.sv
`default_nettype none

module lc4_core (
   input  wire                gwe,
   input  wire                i_reset,
   output lc4_pkg::word_t     o_pc,         // Imem address
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::word_t     o_dmem_addr,
   input  wire lc4_pkg::word_t i_dmem_data,
   output wire                o_dmem_we,
   output lc4_pkg::word_t     o_dmem_wdata
);

   import lc4_pkg::*;

   // F/D
   word_t    d_insn, d_pc;
   logic     d_stall;
   // D/X
   alu_op_e  x_op;
   word_t    x_imm, x_rs_val, x_rt_val, x_pc, x_target;
   reg_sel_t x_rs, x_rt, x_rd, x_fb_rd;
   logic     x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch, x_is_jmp;
   logic     x_use_imm, x_redirect, x_fb_is_load;
   logic [2:0] x_nzp;
   // X/M and M/W
   word_t    m_alu, m_rt_val, m_fwd_data, w_data;
   reg_sel_t m_rt, m_rd, m_fwd_rd, w_rd;
   logic     m_regfile_we, m_is_load, m_is_store, m_fwd_we, w_we;

   lc4_fetch fetch_i (
      .gwe(gwe), .i_reset(i_reset),
      .i_stall(d_stall), .i_redirect(x_redirect), .i_target(x_target),
      .i_insn(i_insn), .o_pc(o_pc), .o_d_insn(d_insn), .o_d_pc(d_pc)
   );

   lc4_decode decode_i (
      .gwe(gwe), .i_reset(i_reset),
      .i_insn(d_insn), .i_pc(d_pc), .i_flush(x_redirect),
      .i_x_is_load(x_fb_is_load), .i_x_rd(x_fb_rd),
      .i_w_we(w_we), .i_w_rd(w_rd), .i_w_data(w_data),
      .o_stall(d_stall), .o_x_op(x_op), .o_x_imm(x_imm),
      .o_x_rs(x_rs), .o_x_rt(x_rt), .o_x_rd(x_rd),
      .o_x_rs_val(x_rs_val), .o_x_rt_val(x_rt_val),
      .o_x_regfile_we(x_regfile_we), .o_x_nzp_we(x_nzp_we),
      .o_x_is_load(x_is_load), .o_x_is_store(x_is_store),
      .o_x_is_branch(x_is_branch), .o_x_is_jmp(x_is_jmp),
      .o_x_use_imm(x_use_imm), .o_x_nzp(x_nzp), .o_x_pc(x_pc)
   );

   lc4_execute execute_i (
      .gwe(gwe), .i_reset(i_reset),
      .i_op(x_op), .i_imm(x_imm), .i_rs(x_rs), .i_rt(x_rt), .i_rd(x_rd),
      .i_rs_val(x_rs_val), .i_rt_val(x_rt_val),
      .i_regfile_we(x_regfile_we), .i_nzp_we(x_nzp_we),
      .i_is_load(x_is_load), .i_is_store(x_is_store),
      .i_is_branch(x_is_branch), .i_is_jmp(x_is_jmp),
      .i_use_imm(x_use_imm), .i_nzp(x_nzp), .i_pc(x_pc),
      .i_m_we(m_fwd_we), .i_m_rd(m_fwd_rd), .i_m_data(m_fwd_data),
      .i_w_we(w_we), .i_w_rd(w_rd), .i_w_data(w_data),
      .o_redirect(x_redirect), .o_target(x_target),
      .o_x_is_load(x_fb_is_load), .o_x_rd(x_fb_rd),
      .o_m_alu(m_alu), .o_m_rt_val(m_rt_val), .o_m_rt(m_rt), .o_m_rd(m_rd),
      .o_m_regfile_we(m_regfile_we), .o_m_is_load(m_is_load),
      .o_m_is_store(m_is_store)
   );

   lc4_result result_i (
      .gwe(gwe), .i_reset(i_reset),
      .i_m_alu(m_alu), .i_m_rt_val(m_rt_val), .i_m_rt(m_rt), .i_m_rd(m_rd),
      .i_m_regfile_we(m_regfile_we), .i_m_is_load(m_is_load),
      .i_m_is_store(m_is_store), .i_dmem_data(i_dmem_data),
      .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
      .o_m_we(m_fwd_we), .o_m_rd(m_fwd_rd), .o_m_data(m_fwd_data),
      .o_w_we(w_we), .o_w_rd(w_rd), .o_w_data(w_data)
   );

endmodule

`default_nettype wire

//--- bench/lc4_programs.svh
`ifndef LC4_PROGRAMS_SVH
`define LC4_PROGRAMS_SVH

// ========================================
// Directed programs
// ========================================
// Each entry: name, code at 8200h, expected words at data addresses
task automatic build_directed();
   logic [15:0] r0, r1, r2, r3, r4, r5, r6;
   int t;
   t = 0;

   // Dependent ALU chain, MX and WX paths
   names[t] = "alu_chain";
   r1 = 16'd182;
   r2 = r1 + r1;
   r3 = r2 - r1;
   r4 = r3 & r2;
   r5 = r4 | r1;
   r6 = r5 ^ r2;
   r0 = r6 + 16'hFFFD;                      // imm5 of -3
   push_insn(t, const_word(7, 64));         // Base address
   push_insn(t, const_word(1, 182));
   push_insn(t, rrr_word(OPC_ARITH, 0, 2, 1, 1));
   push_insn(t, rrr_word(OPC_ARITH, 2, 3, 2, 1));
   push_insn(t, rrr_word(OPC_LOGIC, 0, 4, 3, 2));
   push_insn(t, rrr_word(OPC_LOGIC, 2, 5, 4, 1));
   push_insn(t, rrr_word(OPC_LOGIC, 3, 6, 5, 2));
   push_insn(t, addi_word(0, 6, -3));
   push_insn(t, mem_word(OPC_STR, 3, 7, 0));
   push_insn(t, mem_word(OPC_STR, 4, 7, 1));
   push_insn(t, mem_word(OPC_STR, 6, 7, 2));
   push_insn(t, mem_word(OPC_STR, 0, 7, 3));
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, r3);
   expect_word(t, 16'd65, r4);
   expect_word(t, 16'd66, r6);
   expect_word(t, 16'd67, r0);
   t++;

   // Load then dependent ADD, one stall
   names[t] = "load_use";
   push_insn(t, const_word(7, 64));
   push_insn(t, const_word(3, 100));
   push_insn(t, mem_word(OPC_LDR, 1, 7, 5));
   push_insn(t, rrr_word(OPC_ARITH, 0, 2, 1, 3));
   push_insn(t, mem_word(OPC_STR, 2, 7, 0));
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, fill_word(16'd69) + 16'd100);
   t++;

   // BR on N and Z, taken and not taken
   names[t] = "br_neg_zero";
   push_insn(t, const_word(7, 64));
   push_insn(t, const_word(2, 'h11));       // Marker A
   push_insn(t, const_word(3, 'h22));       // Marker B
   push_insn(t, const_word(1, -2));         // NZP = N
   push_insn(t, br_word(3'b011, 1));        // Not taken
   push_insn(t, mem_word(OPC_STR, 2, 7, 0));
   push_insn(t, br_word(3'b100, 1));        // Taken
   push_insn(t, mem_word(OPC_STR, 3, 7, 1)); // Flushed
   push_insn(t, addi_word(1, 1, 2));        // NZP = Z
   push_insn(t, br_word(3'b101, 1));        // Not taken
   push_insn(t, mem_word(OPC_STR, 3, 7, 2));
   push_insn(t, br_word(3'b010, 1));        // Taken
   push_insn(t, mem_word(OPC_STR, 2, 7, 3)); // Flushed
   push_insn(t, addi_word(1, 1, 1));
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, 16'h0011);
   expect_word(t, 16'd65, fill_word(16'd65));
   expect_word(t, 16'd66, 16'h0022);
   expect_word(t, 16'd67, fill_word(16'd67));
   t++;

   // BR on P, both flushed slots hold stores
   names[t] = "br_pos";
   push_insn(t, const_word(7, 64));
   push_insn(t, const_word(2, 'h33));
   push_insn(t, const_word(1, 7));          // NZP = P
   push_insn(t, br_word(3'b110, 1));        // Not taken
   push_insn(t, mem_word(OPC_STR, 2, 7, 0));
   push_insn(t, br_word(3'b001, 2));        // Taken
   push_insn(t, mem_word(OPC_STR, 2, 7, 1));
   push_insn(t, mem_word(OPC_STR, 2, 7, 2));
   push_insn(t, mem_word(OPC_STR, 2, 7, 3));
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, 16'h0033);
   expect_word(t, 16'd65, fill_word(16'd65));
   expect_word(t, 16'd66, fill_word(16'd66));
   expect_word(t, 16'd67, 16'h0033);
   t++;

   // JMP over two stores
   names[t] = "jmp_skip";
   push_insn(t, const_word(7, 64));
   push_insn(t, const_word(1, 'h55));
   push_insn(t, jmp_word(2));
   push_insn(t, mem_word(OPC_STR, 1, 7, 0)); // Sentinel store
   push_insn(t, mem_word(OPC_STR, 1, 7, 1));
   push_insn(t, mem_word(OPC_STR, 1, 7, 2)); // Jump target
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, fill_word(16'd64));
   expect_word(t, 16'd65, fill_word(16'd65));
   expect_word(t, 16'd66, 16'h0055);
   t++;

   // Load then store of the same register
   names[t] = "wm_bypass";
   push_insn(t, const_word(7, 64));
   push_insn(t, mem_word(OPC_LDR, 1, 7, 8));
   push_insn(t, mem_word(OPC_STR, 1, 7, 0));
   push_insn(t, mem_word(OPC_LDR, 2, 7, 9));
   push_insn(t, mem_word(OPC_STR, 2, 7, 1));
   push_insn(t, jmp_word(-1));
   expect_word(t, 16'd64, fill_word(16'd72));
   expect_word(t, 16'd65, fill_word(16'd73));
endtask

`endif

//--- bench/lc4_core_tb.sv
`default_nettype none

module lc4_core_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_DIR    = 6;
   localparam int N_RAND   = 4;
   localparam int N_TEST   = N_DIR + N_RAND;
   localparam int BUDGET   = 60;                      // Cycles per program
   localparam int WATCH_NS = N_TEST * BUDGET * 4 * 2;

   // Major opcodes for the encoders
   localparam int OPC_ARITH = 1;
   localparam int OPC_LOGIC = 5;
   localparam int OPC_LDR   = 6;
   localparam int OPC_STR   = 7;

   logic        gwe;
   logic        i_reset;
   logic [15:0] i_insn, i_dmem_data;
   logic [15:0] o_pc, o_dmem_addr, o_dmem_wdata;
   wire         o_dmem_we;
   logic        fill_dmem;                            // Reload data memory

   logic [15:0] imem [0:65535];
   logic [15:0] dmem [0:65535];

   // Test table
   string       names [N_TEST];
   logic [15:0] code [N_TEST][16];
   int          ncode [N_TEST];
   logic [15:0] exp_addr [N_TEST][4];
   logic [15:0] exp_val [N_TEST][4];
   int          nexp [N_TEST];
   logic [31:0] lcg_state;

   lc4_core dut_i (
      .gwe(gwe), .i_reset(i_reset),
      .o_pc(o_pc), .i_insn(i_insn),
      .o_dmem_addr(o_dmem_addr), .i_dmem_data(i_dmem_data),
      .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata)
   );

   initial begin
      gwe = 1'b0;
      forever #2 gwe = ~gwe;                          // 4 ns period
   end

   // ========================================
   // Memory models
   // ========================================
   assign i_insn      = imem[o_pc];                   // Combinational fetch
   assign i_dmem_data = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (fill_dmem) begin
         for (int a = 0; a < 65536; a++) begin
            dmem[a] = fill_word(16'(a));
         end
      end else if (o_dmem_we === 1'b1) begin
         dmem[o_dmem_addr] = o_dmem_wdata;            // Store lands at closing edge
      end
   end

   // Initial contents with every address distinct
   function automatic logic [15:0] fill_word(input logic [15:0] a);
      return {a[7:0], a[15:8]} ^ 16'hC35A;
   endfunction

   // Instruction encoders
   function automatic logic [15:0] const_word(input int rd, input int imm);
      return {4'b1001, 3'(rd), 9'(imm)};
   endfunction

   function automatic logic [15:0] rrr_word(input int op, input int sub,
                                             input int rd, input int rs, input int rt);
      return {4'(op), 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
   endfunction

   function automatic logic [15:0] addi_word(input int rd, input int rs, input int imm);
      return {4'b0001, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
   endfunction

   function automatic logic [15:0] mem_word(input int op, input int r,
                                             input int base, input int off);
      return {4'(op), 3'(r), 3'(base), 6'(off)};
   endfunction

   function automatic logic [15:0] br_word(input logic [2:0] nzp, input int off);
      return {4'b0000, nzp, 9'(off)};
   endfunction

   function automatic logic [15:0] jmp_word(input int off);
      return {4'b1100, 1'b1, 11'(off)};                // -1 jumps to itself
   endfunction

   task automatic push_insn(input int t, input logic [15:0] w);
      code[t][ncode[t]] = w;
      ncode[t]++;
   endtask

   task automatic expect_word(input int t, input logic [15:0] a, input logic [15:0] v);
      exp_addr[t][nexp[t]] = a;
      exp_val[t][nexp[t]]  = v;
      nexp[t]++;
   endtask

   `include "lc4_programs.svh"

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return 32'(lcg_state[30:15]);
   endfunction

   // ========================================
   // Random straight-line programs
   // ========================================
   task automatic make_random(input int t);
      logic [15:0] m [4];                             // Model of R0..R3
      int v, kind, rd, rs, rt;
      names[t] = $sformatf("random_%0d", t - N_DIR);
      for (int r = 0; r < 4; r++) begin
         v = int'(lcg_next() % 512) - 256;
         m[r] = 16'(v);                               // imm9 sign extension
         push_insn(t, const_word(r, v));
      end
      push_insn(t, const_word(7, 64));
      for (int i = 0; i < 6; i++) begin
         kind = int'(lcg_next() % 7);
         rd   = int'(lcg_next() % 4);
         rs   = int'(lcg_next() % 4);
         rt   = int'(lcg_next() % 4);
         case (kind)
            0: begin
               m[rd] = m[rs] + m[rt];
               push_insn(t, rrr_word(OPC_ARITH, 0, rd, rs, rt));
            end
            1: begin
               m[rd] = m[rs] - m[rt];
               push_insn(t, rrr_word(OPC_ARITH, 2, rd, rs, rt));
            end
            2: begin
               m[rd] = m[rs] & m[rt];
               push_insn(t, rrr_word(OPC_LOGIC, 0, rd, rs, rt));
            end
            3: begin
               m[rd] = m[rs] | m[rt];
               push_insn(t, rrr_word(OPC_LOGIC, 2, rd, rs, rt));
            end
            4: begin
               m[rd] = m[rs] ^ m[rt];
               push_insn(t, rrr_word(OPC_LOGIC, 3, rd, rs, rt));
            end
            5: begin
               v = int'(lcg_next() % 32) - 16;        // imm5 range
               m[rd] = m[rs] + 16'(v);
               push_insn(t, addi_word(rd, rs, v));
            end
            default: begin
               v = int'(lcg_next() % 512) - 256;
               m[rd] = 16'(v);
               push_insn(t, const_word(rd, v));
            end
         endcase
      end
      for (int r = 0; r < 4; r++) begin
         push_insn(t, mem_word(OPC_STR, r, 7, r));
         expect_word(t, 16'(64 + r), m[r]);
      end
      push_insn(t, jmp_word(-1));
   endtask

   // Load, reset, run the budget, compare memory
   task automatic run_test(input int t, output int bad);
      @(posedge gwe);
      #1;
      i_reset   = 1'b1;
      fill_dmem = 1'b1;
      for (int k = 0; k < 256; k++) begin
         imem[16'(32'h8200 + k)] = 16'h0000;          // NOP padding
      end
      for (int k = 0; k < ncode[t]; k++) begin
         imem[16'(32'h8200 + k)] = code[t][k];
      end
      @(posedge gwe);
      #1 fill_dmem = 1'b0;
      repeat (9) @(posedge gwe);
      #1 i_reset = 1'b0;
      repeat (BUDGET) @(posedge gwe);
      #1;
      bad = 0;
      for (int k = 0; k < nexp[t]; k++) begin
         assert (dmem[exp_addr[t][k]] === exp_val[t][k]) else begin
            $display("[ERROR] %s: mem[%h] expected %h actual %h", names[t],
                     exp_addr[t][k], exp_val[t][k], dmem[exp_addr[t][k]]);
            bad++;
         end
      end
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      int bad;
      int n_pass;
      int n_fail;
      i_reset   = 1'b1;
      fill_dmem = 1'b0;
      lcg_state = 32'd13046;
      n_pass    = 0;
      n_fail    = 0;
      for (int t = 0; t < N_TEST; t++) begin
         ncode[t] = 0;
         nexp[t]  = 0;
      end
      build_directed();
      for (int t = N_DIR; t < N_TEST; t++) begin
         make_random(t);
      end
      for (int t = 0; t < N_TEST; t++) begin
         run_test(t, bad);
         if (bad == 0) begin
            $display("%-14s ok", names[t]);
            n_pass++;
         end else begin
            $display("%-14s failed, %0d mismatches", names[t], bad);
            n_fail++;
         end
      end
      $display("%0d tests, %0d passed, %0d failed", N_TEST, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog at twice the total budget
   initial begin
      #(WATCH_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCH_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
+incdir+bench
rtl/lc4_pkg.sv
rtl/lc4_fetch.sv
rtl/lc4_decode.sv
rtl/lc4_execute.sv
rtl/lc4_result.sv
rtl/lc4_core.sv
bench/lc4_core_tb.sv

//--- Makefile
# Verilator build and run for the LC4 pipeline testbench

VERILATOR ?= verilator
TOP       ?= lc4_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv bench/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
